// ==== logic/pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// machine widths, all fixed by the ISA
`define PIPE_DATA_WIDTH  16
`define PIPE_INSTR_WIDTH 16
`define PIPE_REG_COUNT   8
`define PIPE_REG_BITS    3
`define PIPE_IMM_BITS    6
`define PIPE_SHAMT_BITS  4  // slli shifts by the low bits of the immediate field

// instruction word layout
`define PIPE_OP_MSB 15
`define PIPE_OP_LSB 12
`define PIPE_RD_MSB 11
`define PIPE_RD_LSB 9
`define PIPE_RS_MSB 8
`define PIPE_RS_LSB 6
`define PIPE_RT_MSB 5
`define PIPE_RT_LSB 3

`endif

// ==== logic/isa_pkg.sv ====
`include "pipe_config.svh"

package isa_pkg;

  // opcode field of the instruction word, encodings 8 to 15 are unused
  typedef enum logic [`PIPE_OP_MSB-`PIPE_OP_LSB:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_addi = 4'd6,
    op_slli = 4'd7
  } opcode_e;

  // control fields produced by decode
  // an all-zero value is a nop that writes nothing
  typedef struct packed {
    opcode_e                     opcode;
    logic [`PIPE_REG_BITS-1:0]   rd;
    logic [`PIPE_REG_BITS-1:0]   rs;
    logic [`PIPE_REG_BITS-1:0]   rt;
    logic [`PIPE_DATA_WIDTH-1:0] imm;       // already extended to the datapath width
    logic                        use_imm;   // second operand comes from imm, not rt
    logic                        write_en;
  } decoded_t;

endpackage

// ==== logic/pipe_pkg.sv ====
`include "pipe_config.svh"

package pipe_pkg;

  // contents of the decode to execute register
  // flush and bubble both produce the zero value, which is a nop with write_en low
  typedef struct packed {
    isa_pkg::decoded_t dec;
  } id_ex_t;

  // contents of the execute to write-back register
  // this also drives the register file write port
  typedef struct packed {
    logic                        write_en;
    logic [`PIPE_REG_BITS-1:0]   dst;
    logic [`PIPE_DATA_WIDTH-1:0] data;
  } ex_wb_t;

endpackage

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module decode_stage (
  input  logic [`PIPE_INSTR_WIDTH-1:0] instr,
  input  logic                         instr_valid,
  output pipe_pkg::id_ex_t             decoded
);

  logic [`PIPE_OP_MSB-`PIPE_OP_LSB:0] op_field;
  logic [`PIPE_IMM_BITS-1:0]          imm_field;
  isa_pkg::opcode_e                   opcode;
  isa_pkg::decoded_t                  dec;

  assign op_field  = instr[`PIPE_OP_MSB:`PIPE_OP_LSB];
  assign imm_field = instr[`PIPE_IMM_BITS-1:0];

  always_comb begin
    case (op_field)
      isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_or,
      isa_pkg::op_xor, isa_pkg::op_addi, isa_pkg::op_slli: begin
        opcode = isa_pkg::opcode_e'(op_field);
      end
      default: begin
        opcode = isa_pkg::op_nop;  // unused encodings behave as nop
      end
    endcase
  end

  always_comb begin
    dec = '0;
    if (instr_valid && opcode != isa_pkg::op_nop) begin
      dec.opcode   = opcode;
      dec.rd       = instr[`PIPE_RD_MSB:`PIPE_RD_LSB];
      dec.rs       = instr[`PIPE_RS_MSB:`PIPE_RS_LSB];
      // r0 is hardwired, so a write to it is simply dropped here
      dec.write_en = (instr[`PIPE_RD_MSB:`PIPE_RD_LSB] != '0);
      case (opcode)
        isa_pkg::op_addi: begin
          dec.imm     = {{(`PIPE_DATA_WIDTH-`PIPE_IMM_BITS){imm_field[`PIPE_IMM_BITS-1]}},
                         imm_field};
          dec.use_imm = 1'b1;
        end
        isa_pkg::op_slli: begin
          dec.imm     = {{(`PIPE_DATA_WIDTH-`PIPE_SHAMT_BITS){1'b0}},
                         imm_field[`PIPE_SHAMT_BITS-1:0]};
          dec.use_imm = 1'b1;
        end
        default: begin
          dec.rt = instr[`PIPE_RT_MSB:`PIPE_RT_LSB];  // only register forms read rt
        end
      endcase
    end
  end

  assign decoded.dec = dec;

endmodule

// ==== logic/id_ex_register.sv ====
`timescale 1ns/1ps

module id_ex_register (
  input  logic             clk,
  input  logic             reset,
  input  logic             hold,
  input  logic             flush,
  input  logic             bubble,
  input  pipe_pkg::id_ex_t d,
  output pipe_pkg::id_ex_t q
);

  pipe_pkg::id_ex_t contents;
  logic             bubble_latch;

  always_ff @(posedge clk) begin
    if (reset) begin
      contents     <= '0;
      bubble_latch <= 1'b0;
    end else begin
      bubble_latch <= bubble;  // sampled every edge, independent of hold
      if (flush) begin
        contents <= '0;
      end else if (!hold) begin
        contents <= d;
      end
    end
  end

  // a latched bubble hides the contents for one cycle without losing them,
  // so a held instruction comes back once the bubble drops
  assign q = bubble_latch ? '0 : contents;

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module register_file (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`PIPE_REG_BITS-1:0]   rs_addr,
  input  logic [`PIPE_REG_BITS-1:0]   rt_addr,
  output logic [`PIPE_DATA_WIDTH-1:0] rs_data,
  output logic [`PIPE_DATA_WIDTH-1:0] rt_data,
  input  pipe_pkg::ex_wb_t            wb
);

  logic [`PIPE_DATA_WIDTH-1:0] regs [`PIPE_REG_COUNT];

  // the write landing at the next edge is visible to the same-cycle read
  function automatic logic [`PIPE_DATA_WIDTH-1:0] read_port(
    input logic [`PIPE_REG_BITS-1:0] addr
  );
    logic [`PIPE_DATA_WIDTH-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (wb.write_en && wb.dst == addr) begin
      value = wb.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `PIPE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.write_en && wb.dst != '0) begin
      regs[wb.dst] <= wb.data;
    end
  end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module execute_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  pipe_pkg::id_ex_t            op,
  output logic [`PIPE_REG_BITS-1:0]   rs_addr,
  output logic [`PIPE_REG_BITS-1:0]   rt_addr,
  input  logic [`PIPE_DATA_WIDTH-1:0] rs_data,
  input  logic [`PIPE_DATA_WIDTH-1:0] rt_data,
  output pipe_pkg::ex_wb_t            wb
);

  logic [`PIPE_DATA_WIDTH-1:0] operand_b;
  logic [`PIPE_DATA_WIDTH-1:0] result;

  // operands are read here, not in decode, so the write-through
  // register file covers a dependency one instruction back
  assign rs_addr = op.dec.rs;
  assign rt_addr = op.dec.rt;

  assign operand_b = op.dec.use_imm ? op.dec.imm : rt_data;

  always_comb begin
    case (op.dec.opcode)
      isa_pkg::op_add, isa_pkg::op_addi: begin
        result = rs_data + operand_b;  // carry out of the top bit is dropped
      end
      isa_pkg::op_sub: begin
        result = rs_data - operand_b;
      end
      isa_pkg::op_and: begin
        result = rs_data & operand_b;
      end
      isa_pkg::op_or: begin
        result = rs_data | operand_b;
      end
      isa_pkg::op_xor: begin
        result = rs_data ^ operand_b;
      end
      isa_pkg::op_slli: begin
        result = rs_data << operand_b[`PIPE_SHAMT_BITS-1:0];
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // ex_wb loads every cycle, a masked or flushed id_ex simply gives write_en low
  always_ff @(posedge clk) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.write_en <= op.dec.write_en;
      wb.dst      <= op.dec.rd;
      wb.data     <= result;
    end
  end

endmodule

// ==== logic/pipe_top.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`PIPE_INSTR_WIDTH-1:0] instr,
  input  logic                         instr_valid,
  input  logic                         hold,
  input  logic                         flush,
  input  logic                         bubble,
  output logic                         wb_en,
  output logic [`PIPE_REG_BITS-1:0]    wb_reg,
  output logic [`PIPE_DATA_WIDTH-1:0]  wb_data
);

  pipe_pkg::id_ex_t            decoded;
  pipe_pkg::id_ex_t            id_ex_q;
  pipe_pkg::ex_wb_t            wb;
  logic [`PIPE_REG_BITS-1:0]   rs_addr;
  logic [`PIPE_REG_BITS-1:0]   rt_addr;
  logic [`PIPE_DATA_WIDTH-1:0] rs_data;
  logic [`PIPE_DATA_WIDTH-1:0] rt_data;

  decode_stage decode_stage_inst (
    .instr       (instr),
    .instr_valid (instr_valid),
    .decoded     (decoded)
  );

  id_ex_register id_ex_register_inst (
    .clk    (clk),
    .reset  (reset),
    .hold   (hold),
    .flush  (flush),
    .bubble (bubble),
    .d      (decoded),
    .q      (id_ex_q)
  );

  execute_stage execute_stage_inst (
    .clk     (clk),
    .reset   (reset),
    .op      (id_ex_q),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb)
  );

  register_file register_file_inst (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb)
  );

  // the write-back register is the observable result of the slice
  assign wb_en   = wb.write_en;
  assign wb_reg  = wb.dst;
  assign wb_data = wb.data;

endmodule

// ==== verification/pipe_checker.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_checker (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`PIPE_INSTR_WIDTH-1:0] instr,
  input  logic                         instr_valid,
  input  logic                         hold,
  input  logic                         flush,
  input  logic                         bubble,
  input  logic [127:0]                 test_name,
  input  logic                         wb_en,
  input  logic [`PIPE_REG_BITS-1:0]    wb_reg,
  input  logic [`PIPE_DATA_WIDTH-1:0]  wb_data,
  output int                           error_count,
  output int                           check_count,
  output logic                         idle
);

  // id_ex modelled as the raw word plus a live flag, decoded when it executes
  logic [`PIPE_INSTR_WIDTH-1:0] held_word = '0;
  logic                         held_live = 1'b0;
  logic [127:0]                 held_name = "reset";
  logic                         masked = 1'b0;  // the latched bubble
  logic [`PIPE_DATA_WIDTH-1:0]  regs_m [`PIPE_REG_COUNT];
  logic                         exp_en = 1'b0;
  logic [`PIPE_REG_BITS-1:0]    exp_reg = '0;
  logic [`PIPE_DATA_WIDTH-1:0]  exp_data = '0;
  logic [127:0]                 exp_name = "reset";
  int                           errors = 0;
  int                           checks = 0;

  function automatic logic known_op(input logic [3:0] op);
    return op >= 4'd1 && op <= 4'd7;
  endfunction

  // r0 reads zero, and a result about to be written is already visible
  function automatic logic [`PIPE_DATA_WIDTH-1:0] read_reg(input logic [`PIPE_REG_BITS-1:0] a);
    if (a == '0) return '0;
    if (exp_en && exp_reg == a) return exp_data;
    return regs_m[a];
  endfunction

  function automatic logic [`PIPE_DATA_WIDTH-1:0] alu(input logic [`PIPE_INSTR_WIDTH-1:0] word);
    logic [`PIPE_DATA_WIDTH-1:0] a;
    logic [`PIPE_DATA_WIDTH-1:0] b;
    logic [`PIPE_DATA_WIDTH-1:0] imm_s;
    a = read_reg(word[`PIPE_RS_MSB:`PIPE_RS_LSB]);
    b = read_reg(word[`PIPE_RT_MSB:`PIPE_RT_LSB]);
    imm_s = {{(`PIPE_DATA_WIDTH-`PIPE_IMM_BITS){word[`PIPE_IMM_BITS-1]}},
             word[`PIPE_IMM_BITS-1:0]};
    case (word[`PIPE_OP_MSB:`PIPE_OP_LSB])
      4'd1: return a + b;
      4'd2: return a - b;
      4'd3: return a & b;
      4'd4: return a | b;
      4'd5: return a ^ b;
      4'd6: return a + imm_s;
      4'd7: return a << word[3:0];  // shift amount is the low four immediate bits
      default: return '0;
    endcase
  endfunction

  always @(posedge clk) begin
    logic                        next_en;
    logic [`PIPE_DATA_WIDTH-1:0] next_data;
    if (reset) begin
      held_live = 1'b0;
      held_word = '0;
      held_name = "reset";
      masked = 1'b0;
      exp_en = 1'b0;
      exp_name = "reset";
      for (int i = 0; i < `PIPE_REG_COUNT; i++) regs_m[i] = '0;
    end else begin
      checks++;
      if (wb_en !== exp_en) begin
        errors++;
        $display("Fail %0s: wb_en expected %0b actual %0b", exp_name, exp_en, wb_en);
      end else if (exp_en && (wb_reg !== exp_reg || wb_data !== exp_data)) begin
        errors++;
        $display("Fail %0s: write-back expected r%0d = %h actual r%0d = %h",
                 exp_name, exp_reg, exp_data, wb_reg, wb_data);
      end
      // what id_ex presents this cycle goes into ex_wb at this edge
      next_en = held_live && !masked && held_word[`PIPE_RD_MSB:`PIPE_RD_LSB] != '0;
      next_data = alu(held_word);
      if (exp_en) regs_m[exp_reg] = exp_data;
      exp_en = next_en;
      exp_reg = held_word[`PIPE_RD_MSB:`PIPE_RD_LSB];
      exp_data = next_data;
      exp_name = held_name;
      masked = bubble;
      if (flush) begin
        held_live = 1'b0;
        held_word = '0;
        held_name = test_name;
      end else if (!hold) begin
        held_word = instr;
        held_live = instr_valid && known_op(instr[`PIPE_OP_MSB:`PIPE_OP_LSB]);
        held_name = test_name;
      end
    end
  end

  assign error_count = errors;
  assign check_count = checks;
  assign idle = !held_live && !exp_en;

endmodule

// ==== verification/pipe_tb.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_tb;

  typedef struct packed {
    logic [`PIPE_INSTR_WIDTH-1:0] instr;
    logic                         valid;
    logic                         hold;
    logic                         flush;
    logic                         bubble;
    logic [127:0]                 name;
  } row_t;

  logic                         clk;
  logic                         reset;
  logic [`PIPE_INSTR_WIDTH-1:0] instr;
  logic                         instr_valid;
  logic                         hold;
  logic                         flush;
  logic                         bubble;
  logic [127:0]                 test_name;
  logic                         wb_en;
  logic [`PIPE_REG_BITS-1:0]    wb_reg;
  logic [`PIPE_DATA_WIDTH-1:0]  wb_data;
  int                           error_count;
  int                           check_count;
  logic                         model_idle;
  int                           timeouts;
  row_t                         rows[$];

  always #20 clk = ~clk;

  pipe_top pipe_top_inst (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .hold        (hold),
    .flush       (flush),
    .bubble      (bubble),
    .wb_en       (wb_en),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

  pipe_checker pipe_checker_inst (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .hold        (hold),
    .flush       (flush),
    .bubble      (bubble),
    .test_name   (test_name),
    .wb_en       (wb_en),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .error_count (error_count),
    .check_count (check_count),
    .idle        (model_idle)
  );

  function automatic logic [15:0] r_form(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [2:0] rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  function automatic logic [15:0] i_form(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [5:0] imm);
    return {op, rd, rs, imm};
  endfunction

  task automatic add_row(input logic [15:0] word, input logic v, input logic h,
                         input logic f, input logic b, input logic [127:0] name);
    rows.push_back({word, v, h, f, b, name});
  endtask

  task automatic build_table;
    logic [3:0] op;
    for (int i = 0; i < 3; i++) add_row('0, 1'b0, 1'b0, 1'b0, 1'b0, "after reset");
    add_row(i_form(isa_pkg::op_addi, 3'd1, 3'd0, 6'd5), 1, 0, 0, 0, "addi pos");
    add_row(i_form(isa_pkg::op_addi, 3'd2, 3'd0, 6'h3d), 1, 0, 0, 0, "addi neg");
    add_row(r_form(isa_pkg::op_add, 3'd3, 3'd1, 3'd2), 1, 0, 0, 0, "add");
    add_row(r_form(isa_pkg::op_sub, 3'd4, 3'd1, 3'd2), 1, 0, 0, 0, "sub");
    add_row(r_form(isa_pkg::op_and, 3'd5, 3'd1, 3'd2), 1, 0, 0, 0, "and");
    add_row(r_form(isa_pkg::op_or, 3'd6, 3'd1, 3'd2), 1, 0, 0, 0, "or");
    add_row(r_form(isa_pkg::op_xor, 3'd7, 3'd1, 3'd2), 1, 0, 0, 0, "xor");
    add_row(i_form(isa_pkg::op_slli, 3'd3, 3'd2, 6'h0f), 1, 0, 0, 0, "slli");
    add_row(r_form(isa_pkg::op_add, 3'd0, 3'd1, 3'd2), 1, 0, 0, 0, "write r0");
    add_row(r_form(isa_pkg::op_add, 3'd4, 3'd0, 3'd1), 1, 0, 0, 0, "read r0");
    add_row(r_form(isa_pkg::op_add, 3'd5, 3'd6, 3'd6), 1, 0, 0, 0, "add wrap");
    add_row(r_form(isa_pkg::op_sub, 3'd5, 3'd0, 3'd1), 1, 0, 0, 0, "sub wrap");
    add_row(i_form(isa_pkg::op_addi, 3'd1, 3'd1, 6'd1), 1, 0, 0, 0, "dep d1 first");
    add_row(i_form(isa_pkg::op_addi, 3'd1, 3'd1, 6'd1), 1, 0, 0, 0, "dep d1 second");
    add_row(i_form(isa_pkg::op_addi, 3'd6, 3'd1, 6'd2), 1, 0, 0, 0, "dep d2 a");
    add_row(i_form(isa_pkg::op_addi, 3'd7, 3'd2, 6'd1), 1, 0, 0, 0, "dep d2 b");
    add_row(r_form(isa_pkg::op_add, 3'd3, 3'd6, 3'd7), 1, 0, 0, 0, "dep d2 use");
    add_row({4'hb, 12'hfff}, 1, 0, 0, 0, "unknown op");
    add_row(r_form(isa_pkg::op_add, 3'd4, 3'd1, 3'd1), 1, 0, 1, 0, "flush");
    add_row(r_form(isa_pkg::op_add, 3'd5, 3'd1, 3'd1), 1, 0, 0, 1, "bubble");
    add_row(i_form(isa_pkg::op_addi, 3'd1, 3'd1, 6'd3), 1, 0, 0, 0, "hb target");
    // the words under hold must be ignored by the DUT
    add_row(r_form(isa_pkg::op_xor, 3'd6, 3'd6, 3'd6), 1, 1, 0, 1, "hold bubble");
    add_row(r_form(isa_pkg::op_xor, 3'd6, 3'd6, 3'd6), 1, 1, 0, 0, "hold after hb");
    add_row(r_form(isa_pkg::op_add, 3'd2, 3'd1, 3'd0), 1, 0, 0, 0, "after hb");
    add_row(i_form(isa_pkg::op_addi, 3'd1, 3'd1, 6'd4), 1, 0, 0, 0, "hold target");
    add_row(r_form(isa_pkg::op_xor, 3'd7, 3'd7, 3'd7), 1, 1, 0, 0, "hold alone");
    add_row(r_form(isa_pkg::op_add, 3'd3, 3'd1, 3'd1), 1, 0, 0, 0, "after hold");
    for (int i = 0; i < 40; i++) begin
      op = 4'($urandom_range(0, 9));  // a few unknown opcodes on purpose
      add_row({op, 12'($urandom)}, $urandom_range(0, 7) != 0, $urandom_range(0, 5) == 0,
              $urandom_range(0, 9) == 0, $urandom_range(0, 7) == 0, "random");
    end
    for (int i = 0; i < 4; i++) add_row('0, 1'b0, 1'b0, 1'b0, 1'b0, "drain");
  endtask

  initial begin
    int waited;
    clk = 1'b0;
    reset = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    hold = 1'b0;
    flush = 1'b0;
    bubble = 1'b0;
    test_name = "reset";
    timeouts = 0;
    void'($urandom(32'h92ed6d6a));
    build_table();
    for (int c = 0; c < 10; c++) @(posedge clk);
    reset <= 1'b0;
    foreach (rows[i]) begin
      @(posedge clk);
      instr <= rows[i].instr;
      instr_valid <= rows[i].valid;
      hold <= rows[i].hold;
      flush <= rows[i].flush;
      bubble <= rows[i].bubble;
      test_name <= rows[i].name;
    end
    waited = 0;
    @(negedge clk);
    while (!model_idle && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (!model_idle) begin
      $display("timeout: the pipeline did not drain within 40 cycles");
      timeouts++;
    end
    repeat (2) @(posedge clk);  // last comparison of the empty pipeline
    @(negedge clk);
    $display("errors: %0d mismatches, %0d timeouts, %0d cycles compared",
             error_count, timeouts, check_count);
    if (error_count == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_stage.sv
logic/id_ex_register.sv
logic/register_file.sv
logic/execute_stage.sv
logic/pipe_top.sv
verification/pipe_checker.sv
verification/pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then decide from the simulation log
verilator --binary --top-module pipe_tb -f list.f -o pipe_sim > build.log 2>&1 \
  && ./obj_dir/pipe_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "All checks passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
